// ==== Makefile ====
# Verilator build, run, lint and clean for the memory path testbench

VERILATOR  ?= verilator
TOP        ?= tb_mem_subsys
RTL_TOP    ?= mem_subsys
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Result: PASSED
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/align_check.sv ====
// alignment checker: odd-address trap, byte-lane enables
// and write-data lane steering

`timescale 1ns/1ns

module align_check (
   input  logic                              sysclk,
   input  logic                              rst,
   bus_req_if.align_side                     req,
   output logic                              odd,
   output logic                              ub_en,
   output logic                              lb_en,
   output logic [bus_pkg::data_width-1:0]    lane_wdata,
   output logic                              align_valid
);

   logic                              odd_c;
   logic                              ub_c;
   logic                              lb_c;
   logic [bus_pkg::data_width-1:0]    lane_c;

   // word at odd address traps
   assign odd_c = !req.byte_op && req.va[0];

   // words use both lanes, bytes pick a lane by va bit 0
   assign ub_c = !req.byte_op || req.va[0];
   assign lb_c = !req.byte_op || !req.va[0];

   // byte data goes to both lanes, the lane enables pick one
   assign lane_c = req.byte_op ? {req.wdata[7:0], req.wdata[7:0]} : req.wdata;

   always_ff @(posedge sysclk)
   begin
      if (rst)
      begin
         align_valid <= 1'b0;
         odd         <= 1'b0;
      end
      else
      begin
         align_valid <= req.strobe;
         if (req.strobe)
            odd <= odd_c;
      end
   end

   always_ff @(posedge sysclk)
   begin
      if (req.strobe)
      begin
         ub_en      <= ub_c;
         lb_en      <= lb_c;
         lane_wdata <= lane_c;
      end
   end

endmodule

// ==== rtl/bus_control.sv ====
// bus controller: joins mapping and alignment results,
// runs the async SRAM cycle and returns data, ack or error

`timescale 1ns/1ns

module bus_control #(
   parameter int RAM_WAIT = 2
) (
   input  logic                              sysclk,
   input  logic                              rst,
   input  bus_pkg::bus_kind_e                kind,
   input  logic                              byte_hi,
   input  logic [bus_pkg::pa_width-1:0]      pa,
   input  logic                              abort,
   input  logic                              map_valid,
   input  logic                              odd,
   input  logic                              ub_en,
   input  logic                              lb_en,
   input  logic [bus_pkg::data_width-1:0]    lane_wdata,
   input  logic                              align_valid,
   output logic [bus_pkg::pa_width-2:0]      ram_a,
   output logic [bus_pkg::data_width-1:0]    ram_wdata,
   input  logic [bus_pkg::data_width-1:0]    ram_rdata,
   output logic                              ram_ce_n,
   output logic                              ram_oe_n,
   output logic                              ram_we_n,
   output logic                              ram_ub_n,
   output logic                              ram_lb_n,
   output logic [bus_pkg::data_width-1:0]    rdata,
   output logic                              ack,
   output logic                              err,
   output bus_pkg::bus_status_e              err_status
);

   localparam int cnt_w = (RAM_WAIT > 1) ? $clog2(RAM_WAIT) : 1;

   typedef enum logic [1:0]
   {
      st_idle   = 2'd0,
      st_check  = 2'd1,
      st_access = 2'd2
   } state_e;

   state_e                            state;
   logic [cnt_w-1:0]                  wait_cnt;
   logic                              abort_q;
   logic                              odd_q;
   logic                              ub_q;
   logic                              lb_q;
   logic [bus_pkg::data_width-1:0]    rd_steer;

   // byte reads come back zero-extended in the low lane
   always_comb
   begin
      if (ub_q ^ lb_q)
         rd_steer = byte_hi ? {8'h00, ram_rdata[15:8]} : {8'h00, ram_rdata[7:0]};
      else
         rd_steer = ram_rdata;
   end

   // ---------------------------------------------------------------------------
   // access FSM
   // ---------------------------------------------------------------------------
   always_ff @(posedge sysclk)
   begin
      if (rst)
      begin
         state      <= st_idle;
         wait_cnt   <= '0;
         abort_q    <= 1'b0;
         odd_q      <= 1'b0;
         ack        <= 1'b0;
         err        <= 1'b0;
         err_status <= bus_pkg::status_ok;
         ram_ce_n   <= 1'b1;
         ram_oe_n   <= 1'b1;
         ram_we_n   <= 1'b1;
         ram_ub_n   <= 1'b1;
         ram_lb_n   <= 1'b1;
      end
      else
      begin
         ack <= 1'b0;
         err <= 1'b0;
         case (state)
            st_idle:
            begin
               if (map_valid && align_valid)
               begin
                  abort_q <= abort;
                  odd_q   <= odd;
                  state   <= st_check;
               end
            end
            st_check:
            begin
               if (abort_q || odd_q)
               begin
                  err        <= 1'b1;
                  err_status <= abort_q ? bus_pkg::status_abort : bus_pkg::status_odd;
                  state      <= st_idle;
               end
               else
               begin
                  ram_ce_n <= 1'b0;
                  ram_oe_n <= (kind != bus_pkg::bus_read);
                  ram_we_n <= (kind != bus_pkg::bus_write);
                  ram_ub_n <= !ub_q;
                  ram_lb_n <= !lb_q;
                  wait_cnt <= cnt_w'(RAM_WAIT - 1);
                  state    <= st_access;
               end
            end
            st_access:
            begin
               if (wait_cnt == '0)
               begin
                  ram_ce_n   <= 1'b1;
                  ram_oe_n   <= 1'b1;
                  ram_we_n   <= 1'b1;
                  ram_ub_n   <= 1'b1;
                  ram_lb_n   <= 1'b1;
                  ack        <= 1'b1;
                  err_status <= bus_pkg::status_ok;
                  state      <= st_idle;
               end
               else
                  wait_cnt <= wait_cnt - 1'b1;
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   // address, lanes and write data held for the whole cycle
   always_ff @(posedge sysclk)
   begin
      if ((state == st_idle) && map_valid && align_valid)
      begin
         ram_a     <= pa[bus_pkg::pa_width-1:1];
         ram_wdata <= lane_wdata;
         ub_q      <= ub_en;
         lb_q      <= lb_en;
      end
   end

   // read data sampled as the strobes rise
   always_ff @(posedge sysclk)
   begin
      if ((state == st_access) && (wait_cnt == '0))
         rdata <= rd_steer;
   end

endmodule

// ==== rtl/bus_pkg.sv ====
// bus widths, the I/O page base, the access kind
// and the completion status of one bus access

package bus_pkg;

   // ---------------------------------------------------------------------------
   // widths
   // ---------------------------------------------------------------------------

   // virtual address seen by the CPU side
   localparam int va_width = 16;

   // physical byte address, 256 KB
   localparam int pa_width = 18;

   localparam int data_width = 16;

   // 760000 octal, top 8 KB of physical space
   localparam logic [pa_width-1:0] io_page_base = 18'o760000;

   // ---------------------------------------------------------------------------
   // access kind and completion status
   // ---------------------------------------------------------------------------

   typedef enum logic
   {
      bus_read  = 1'b0,
      bus_write = 1'b1
   } bus_kind_e;

   // abort wins over odd when both apply
   typedef enum logic [1:0]
   {
      status_ok    = 2'd0,
      status_abort = 2'd1,
      status_odd   = 2'd2
   } bus_status_e;

endpackage

// ==== rtl/bus_req_if.sv ====
// held bus request shared by the mapping unit
// and the alignment checker

`timescale 1ns/1ns

interface bus_req_if;

   // one-cycle request pulse, the rest is held until ack or err
   logic                              strobe;
   bus_pkg::bus_kind_e                kind;
   logic                              byte_op;
   logic [bus_pkg::va_width-1:0]      va;
   logic [bus_pkg::data_width-1:0]    wdata;

   modport src (output strobe, kind, byte_op, va, wdata);

   modport map_side (input strobe, kind, va);

   modport align_side (input strobe, byte_op, va, wdata);

endinterface

// ==== rtl/mem_subsys.sv ====
// memory path top level: request interface, mapping unit,
// alignment checker and SRAM bus controller

`timescale 1ns/1ns

module mem_subsys #(
   parameter int RAM_WAIT = 2
) (
   input  logic                              sysclk,
   input  logic                              rst,
   input  logic                              req,
   input  bus_pkg::bus_kind_e                kind,
   input  logic                              byte_op,
   input  logic [bus_pkg::va_width-1:0]      va,
   input  logic [bus_pkg::data_width-1:0]    wdata,
   input  logic                              mmu_en,
   input  logic                              pxr_wr,
   input  logic [3:0]                        pxr_addr,
   input  logic [15:0]                       pxr_data,
   output logic [bus_pkg::data_width-1:0]    rdata,
   output logic                              ack,
   output logic                              err,
   output bus_pkg::bus_status_e              err_status,
   output logic [bus_pkg::pa_width-2:0]      ram_a,
   output logic [bus_pkg::data_width-1:0]    ram_wdata,
   input  logic [bus_pkg::data_width-1:0]    ram_rdata,
   output logic                              ram_ce_n,
   output logic                              ram_oe_n,
   output logic                              ram_we_n,
   output logic                              ram_ub_n,
   output logic                              ram_lb_n
);

   logic [bus_pkg::pa_width-1:0]      pa;
   logic                              abort;
   logic                              map_valid;
   logic                              odd;
   logic                              ub_en;
   logic                              lb_en;
   logic [bus_pkg::data_width-1:0]    lane_wdata;
   logic                              align_valid;
   logic                              byte_hi;

   bus_req_if req_bus ();

   assign req_bus.strobe  = req;
   assign req_bus.kind    = kind;
   assign req_bus.byte_op = byte_op;
   assign req_bus.va      = va;
   assign req_bus.wdata   = wdata;

   assign byte_hi = va[0];

   // ---------------------------------------------------------------------------
   // mapping and alignment run side by side on the same request
   // ---------------------------------------------------------------------------
   mmu_map u_mmu_map (
      .sysclk    (sysclk),
      .rst       (rst),
      .req       (req_bus.map_side),
      .mmu_en    (mmu_en),
      .pxr_wr    (pxr_wr),
      .pxr_addr  (pxr_addr),
      .pxr_data  (pxr_data),
      .pa        (pa),
      .abort     (abort),
      .map_valid (map_valid)
   );

   align_check u_align_check (
      .sysclk      (sysclk),
      .rst         (rst),
      .req         (req_bus.align_side),
      .odd         (odd),
      .ub_en       (ub_en),
      .lb_en       (lb_en),
      .lane_wdata  (lane_wdata),
      .align_valid (align_valid)
   );

   bus_control #(
      .RAM_WAIT (RAM_WAIT)
   ) u_bus_control (
      .sysclk      (sysclk),
      .rst         (rst),
      .kind        (kind),
      .byte_hi     (byte_hi),
      .pa          (pa),
      .abort       (abort),
      .map_valid   (map_valid),
      .odd         (odd),
      .ub_en       (ub_en),
      .lb_en       (lb_en),
      .lane_wdata  (lane_wdata),
      .align_valid (align_valid),
      .ram_a       (ram_a),
      .ram_wdata   (ram_wdata),
      .ram_rdata   (ram_rdata),
      .ram_ce_n    (ram_ce_n),
      .ram_oe_n    (ram_oe_n),
      .ram_we_n    (ram_we_n),
      .ram_ub_n    (ram_ub_n),
      .ram_lb_n    (ram_lb_n),
      .rdata       (rdata),
      .ack         (ack),
      .err         (err),
      .err_status  (err_status)
   );

endmodule

// ==== rtl/mmu_map.sv ====
// kernel page mapping unit: page address and descriptor registers,
// address relocation and the abort decision

`timescale 1ns/1ns

module mmu_map (
   input  logic                            sysclk,
   input  logic                            rst,
   bus_req_if.map_side                     req,
   input  logic                            mmu_en,
   input  logic                            pxr_wr,
   input  logic [3:0]                      pxr_addr,
   input  mmu_pkg::pxr_word_u              pxr_data,
   output logic [bus_pkg::pa_width-1:0]    pa,
   output logic                            abort,
   output logic                            map_valid
);

   logic [11:0]                     par [8];
   mmu_pkg::pdr_t                   pdr [8];
   mmu_pkg::page_sel_t              page;
   logic [6:0]                      block;
   mmu_pkg::pdr_t                   cur_pdr;
   mmu_pkg::pdr_t                   pdr_wr_val;
   logic                            acf_rd_ok;
   logic                            acf_wr_ok;
   logic [bus_pkg::pa_width-1:0]    pa_c;
   logic                            abort_c;

   assign page    = req.va[15:13];
   assign block   = req.va[12:6];
   assign cur_pdr = pdr[page];

   // reserved bits and W are stored as zero
   always_comb
   begin
      pdr_wr_val         = pxr_data.pdr;
      pdr_wr_val.rsv15   = 1'b0;
      pdr_wr_val.rsv7    = 1'b0;
      pdr_wr_val.rsv5_3  = 3'b000;
      pdr_wr_val.written = 1'b0;
   end

   assign acf_rd_ok = (cur_pdr.acf == mmu_pkg::acf_read_only) ||
                      (cur_pdr.acf == mmu_pkg::acf_read_write);
   assign acf_wr_ok = (cur_pdr.acf == mmu_pkg::acf_read_write);

   // ---------------------------------------------------------------------------
   // relocation and abort
   // ---------------------------------------------------------------------------
   always_comb
   begin
      if (mmu_en)
      begin
         pa_c    = {par[page], 6'b000000} + {5'b00000, req.va[12:0]};
         abort_c = !acf_rd_ok ||
                   ((req.kind == bus_pkg::bus_write) && !acf_wr_ok) ||
                   (block > cur_pdr.plen);
      end
      else
      begin
         // unmapped: top 8 KB goes to the I/O page
         if (page == 3'b111)
            pa_c = bus_pkg::io_page_base | {5'b00000, req.va[12:0]};
         else
            pa_c = {2'b00, req.va};
         abort_c = 1'b0;
      end
   end

   // page registers
   always_ff @(posedge sysclk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 8; i++)
         begin
            par[i] <= '0;
            pdr[i] <= '0;
         end
      end
      else
      begin
         if (pxr_wr)
         begin
            if (pxr_addr[3])
               pdr[pxr_addr[2:0]] <= pdr_wr_val;
            else
               par[pxr_addr[2:0]] <= pxr_data.par_w.addr;
         end
      end
   end

   always_ff @(posedge sysclk)
   begin
      if (rst)
      begin
         map_valid <= 1'b0;
         abort     <= 1'b0;
      end
      else
      begin
         map_valid <= req.strobe;
         if (req.strobe)
            abort <= abort_c;
      end
   end

   always_ff @(posedge sysclk)
   begin
      if (req.strobe)
         pa <= pa_c;
   end

endmodule

// ==== rtl/mmu_pkg.sv ====
// page register fields, access-control codes
// and the register write-word union

package mmu_pkg;

   // page number, va bits 15 to 13
   typedef logic [2:0] page_sel_t;

   // any code not listed here behaves as nonresident
   typedef enum logic [2:0]
   {
      acf_nonres     = 3'd0,
      acf_read_only  = 3'd2,
      acf_read_write = 3'd6
   } acf_e;

   // ---------------------------------------------------------------------------
   // page descriptor, 16 bits
   // ---------------------------------------------------------------------------
   typedef struct packed
   {
      logic       rsv15;
      logic [6:0] plen;
      logic       rsv7;
      logic       written;
      logic [2:0] rsv5_3;
      acf_e       acf;
   } pdr_t;

   // page address register as seen in a write word
   typedef struct packed
   {
      logic [3:0]  rsv;
      logic [11:0] addr;
   } par_word_t;

   // one write word, decoded by pxr_addr bit 3
   typedef union packed
   {
      pdr_t      pdr;
      par_word_t par_w;
   } pxr_word_u;

endpackage

// ==== tb.f ====
rtl/bus_pkg.sv
rtl/mmu_pkg.sv
rtl/bus_req_if.sv
rtl/mmu_map.sv
rtl/align_check.sv
rtl/bus_control.sv
rtl/mem_subsys.sv
verification/mem_subsys_checker.sv
verification/tb_mem_subsys.sv

// ==== verification/mem_subsys_checker.sv ====
// concurrent checks on the bus controller: ack and err pulses,
// completion status and SRAM strobe timing

`timescale 1ns/1ns

module mem_subsys_checker (
   input  logic                    sysclk,
   input  logic                    rst,
   input  logic                    ack,
   input  logic                    err,
   input  bus_pkg::bus_status_e    err_status,
   input  logic                    ram_ce_n,
   input  logic                    ram_oe_n,
   input  logic                    ram_we_n,
   input  logic                    ram_ub_n,
   input  logic                    ram_lb_n
);

   a_ack_err_excl: assert property (@(posedge sysclk) disable iff (rst) !(ack && err))
      else $error("ack and err high in the same cycle");

   a_ack_pulse: assert property (@(posedge sysclk) disable iff (rst) ack |=> !ack)
      else $error("ack held longer than one cycle");

   a_err_pulse: assert property (@(posedge sysclk) disable iff (rst) err |=> !err)
      else $error("err held longer than one cycle");

   a_err_cause: assert property (@(posedge sysclk) disable iff (rst)
      err |-> (err_status != bus_pkg::status_ok))
      else $error("err without an error cause");

   // output enable and write enable never overlap
   a_oe_we_excl: assert property (@(posedge sysclk) disable iff (rst) !(!ram_oe_n && !ram_we_n))
      else $error("ram_oe_n and ram_we_n low together");

   a_reset_idle: assert property (@(posedge sysclk)
      rst |=> (ram_ce_n && ram_oe_n && ram_we_n && ram_ub_n && ram_lb_n))
      else $error("SRAM strobes not idle after reset");

endmodule

bind bus_control mem_subsys_checker checker_i (
   .sysclk     (sysclk),
   .rst        (rst),
   .ack        (ack),
   .err        (err),
   .err_status (err_status),
   .ram_ce_n   (ram_ce_n),
   .ram_oe_n   (ram_oe_n),
   .ram_we_n   (ram_we_n),
   .ram_ub_n   (ram_ub_n),
   .ram_lb_n   (ram_lb_n)
);

// ==== verification/tb_mem_subsys.sv ====
// testbench for the memory path: clock, reset, random stimulus,
// behavioral SRAM, reference mapping model and checks

`timescale 1ns/1ns

module tb_mem_subsys;

   localparam int ram_wait   = 3;
   localparam int n_unmapped = 40;
   localparam int n_reloc    = 60;
   localparam int n_alias    = 10;
   localparam int n_abort    = 150;
   localparam int n_pxr      = 64;
   localparam int n_requests = 2 * n_unmapped + n_reloc + 2 * n_alias + n_abort + n_pxr;
   localparam int watchdog_cycles = n_requests * (4 + ram_wait) + 200;

   logic                    sysclk;
   logic                    rst;
   logic                    req;
   bus_pkg::bus_kind_e      kind;
   logic                    byte_op;
   logic [15:0]             va;
   logic [15:0]             wdata;
   logic                    mmu_en;
   logic                    pxr_wr;
   logic [3:0]              pxr_addr;
   logic [15:0]             pxr_data;
   logic [15:0]             rdata;
   logic                    ack;
   logic                    err;
   bus_pkg::bus_status_e    err_status;
   logic [16:0]             ram_a;
   logic [15:0]             ram_wdata;
   logic [15:0]             ram_rdata;
   logic                    ram_ce_n;
   logic                    ram_oe_n;
   logic                    ram_we_n;
   logic                    ram_ub_n;
   logic                    ram_lb_n;

   // SRAM contents and the model's own image of them
   logic [15:0]             sram [131072];
   logic [15:0]             model_mem [131072];
   logic [11:0]             model_par [8];
   logic [2:0]              model_acf [8];
   logic [6:0]              model_plen [8];
   logic                    model_en;

   mem_subsys #(
      .RAM_WAIT (ram_wait)
   ) dut_i (
      .sysclk     (sysclk),
      .rst        (rst),
      .req        (req),
      .kind       (kind),
      .byte_op    (byte_op),
      .va         (va),
      .wdata      (wdata),
      .mmu_en     (mmu_en),
      .pxr_wr     (pxr_wr),
      .pxr_addr   (pxr_addr),
      .pxr_data   (pxr_data),
      .rdata      (rdata),
      .ack        (ack),
      .err        (err),
      .err_status (err_status),
      .ram_a      (ram_a),
      .ram_wdata  (ram_wdata),
      .ram_rdata  (ram_rdata),
      .ram_ce_n   (ram_ce_n),
      .ram_oe_n   (ram_oe_n),
      .ram_we_n   (ram_we_n),
      .ram_ub_n   (ram_ub_n),
      .ram_lb_n   (ram_lb_n)
   );

   always #5 sysclk = ~sysclk;

   // ---------------------------------------------------------------------------
   // behavioral async SRAM
   // ---------------------------------------------------------------------------
   assign ram_rdata = (!ram_ce_n && !ram_oe_n) ? sram[ram_a] : 16'h0000;

   always @(posedge sysclk)
   begin
      if (!ram_ce_n && !ram_we_n)
      begin
         if (!ram_ub_n)
            sram[ram_a][15:8] <= ram_wdata[15:8];
         if (!ram_lb_n)
            sram[ram_a][7:0] <= ram_wdata[7:0];
      end
   end

   function automatic logic [15:0] fill_word(int unsigned a);
      return 16'((a * 32'd40503) ^ (a >> 3));
   endfunction

   function automatic logic [15:0] rand16();
      return 16'($urandom());
   endfunction

   // ---------------------------------------------------------------------------
   // reference model
   // ---------------------------------------------------------------------------
   function automatic logic [17:0] model_pa(logic [15:0] v);
      if (!model_en)
      begin
         if (v[15:13] == 3'b111)
            return 18'o760000 + 18'(v[12:0]);
         return {2'b00, v};
      end
      return {model_par[v[15:13]], 6'b000000} + 18'(v[12:0]);
   endfunction

   function automatic bus_pkg::bus_status_e model_status(bus_pkg::bus_kind_e k, logic b,
                                                         logic [15:0] v);
      logic [2:0] acf;
      logic       abort;
      acf   = model_acf[v[15:13]];
      abort = 1'b0;
      if (model_en)
         abort = !((acf == 3'd2) || (acf == 3'd6)) ||
                 ((k == bus_pkg::bus_write) && (acf != 3'd6)) ||
                 (v[12:6] > model_plen[v[15:13]]);
      if (abort)
         return bus_pkg::status_abort;
      if (!b && v[0])
         return bus_pkg::status_odd;
      return bus_pkg::status_ok;
   endfunction

   task automatic report_error(string msg);
      $display("ERROR %0t: %s", $time, msg);
      $display("Result: FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic write_pxr(logic [3:0] a, mmu_pkg::pxr_word_u w);
      @(posedge sysclk);
      pxr_wr   <= 1'b1;
      pxr_addr <= a;
      pxr_data <= w;
      @(posedge sysclk);
      pxr_wr <= 1'b0;
      if (a[3])
      begin
         model_acf[a[2:0]]  = w.pdr.acf;
         model_plen[a[2:0]] = w.pdr.plen;
      end
      else
         model_par[a[2:0]] = w.par_w.addr;
   endtask

   task automatic load_page(logic [2:0] p, logic [11:0] par, logic [2:0] acf, logic [6:0] plen);
      mmu_pkg::pxr_word_u w;
      w            = '0;
      w.par_w.addr = par;
      write_pxr({1'b0, p}, w);
      w          = '0;
      w.pdr.plen = plen;
      w.pdr.acf  = mmu_pkg::acf_e'(acf);
      write_pxr({1'b1, p}, w);
   endtask

   // one request: drive, wait for ack or err, check against the model
   task automatic run_access(bus_pkg::bus_kind_e k, logic b, logic [15:0] v, logic [15:0] d);
      bus_pkg::bus_status_e exp_status;
      logic [17:0]          exp_pa;
      logic [15:0]          word;
      logic [15:0]          exp_data;
      logic [16:0]          seen_a;
      logic                 strobe_seen;
      int                   cycles;
      exp_status = model_status(k, b, v);
      exp_pa     = model_pa(v);
      word       = model_mem[exp_pa[17:1]];
      if (b)
         exp_data = v[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
      else
         exp_data = word;
      strobe_seen = 1'b0;
      seen_a      = '0;
      cycles      = 0;
      @(posedge sysclk);
      req     <= 1'b1;
      kind    <= k;
      byte_op <= b;
      va      <= v;
      wdata   <= d;
      @(posedge sysclk);
      req <= 1'b0;
      @(negedge sysclk);
      while (!ack && !err)
      begin
         if (!ram_ce_n)
         begin
            strobe_seen = 1'b1;
            seen_a      = ram_a;
         end
         assert (cycles <= ram_wait + 4)
            else report_error($sformatf("no ack or err for va %06o", v));
         @(posedge sysclk);
         cycles++;
         @(negedge sysclk);
      end
      if (exp_status == bus_pkg::status_ok)
      begin
         assert (ack && !err)
            else report_error($sformatf("va %06o expected ack, got err %0d", v, err_status));
         assert (cycles == 2 + ram_wait)
            else report_error($sformatf("va %06o ack after %0d cycles", v, cycles));
         assert (seen_a == exp_pa[17:1])
            else report_error($sformatf("va %06o reached word %06o, expected %06o",
                                        v, seen_a, exp_pa[17:1]));
         if (k == bus_pkg::bus_read)
         begin
            assert (rdata == exp_data)
               else report_error($sformatf("va %06o read %04h, expected %04h",
                                           v, rdata, exp_data));
         end
         else if (!b)
            model_mem[exp_pa[17:1]] = d;
         else if (v[0])
            model_mem[exp_pa[17:1]][15:8] = d[7:0];
         else
            model_mem[exp_pa[17:1]][7:0] = d[7:0];
      end
      else
      begin
         assert (err && !ack && (err_status == exp_status))
            else report_error($sformatf("va %06o expected err %0d, got ack %0b err %0b/%0d",
                                        v, exp_status, ack, err, err_status));
         assert (cycles == 2)
            else report_error($sformatf("va %06o err after %0d cycles", v, cycles));
         assert (!strobe_seen)
            else report_error($sformatf("va %06o SRAM strobed on an error access", v));
      end
   endtask

   // ---------------------------------------------------------------------------
   // stimulus
   // ---------------------------------------------------------------------------
   initial
   begin
      logic [15:0]        v;
      logic [12:0]        off;
      logic               b;
      bus_pkg::bus_kind_e k;
      void'($urandom(32'h3a41));
      sysclk   = 1'b0;
      rst      = 1'b1;
      req      = 1'b0;
      kind     = bus_pkg::bus_read;
      byte_op  = 1'b0;
      va       = '0;
      wdata    = '0;
      mmu_en   = 1'b0;
      pxr_wr   = 1'b0;
      pxr_addr = '0;
      pxr_data = '0;
      model_en = 1'b0;
      for (int i = 0; i < 131072; i++)
      begin
         sram[i]      = fill_word(i);
         model_mem[i] = fill_word(i);
      end
      for (int p = 0; p < 8; p++)
      begin
         model_par[p]  = '0;
         model_acf[p]  = '0;
         model_plen[p] = '0;
      end
      repeat (16) @(posedge sysclk);
      rst <= 1'b0;

      // unmapped write then read back, the top 8 KB lands in the I/O page
      for (int i = 0; i < n_unmapped; i++)
      begin
         b = 1'($urandom_range(0, 1));
         v = rand16();
         if (!b)
            v[0] = 1'b0;
         run_access(bus_pkg::bus_write, b, v, rand16());
         run_access(bus_pkg::bus_read, b, v, 16'h0000);
      end

      // relocation with full-length read-write pages, page 5 aliases page 1
      @(posedge sysclk);
      mmu_en <= 1'b1;
      model_en = 1'b1;
      for (int p = 0; p < 8; p++)
         load_page(3'(p), 12'($urandom()), 3'd6, 7'h7f);
      load_page(3'd5, model_par[1], 3'd6, 7'h7f);
      for (int i = 0; i < n_reloc; i++)
      begin
         k = ($urandom_range(0, 1) == 1) ? bus_pkg::bus_write : bus_pkg::bus_read;
         b = 1'($urandom_range(0, 1));
         v = rand16();
         if (!b)
            v[0] = 1'b0;
         run_access(k, b, v, rand16());
      end
      for (int i = 0; i < n_alias; i++)
      begin
         b   = 1'($urandom_range(0, 1));
         off = 13'($urandom());
         if (!b)
            off[0] = 1'b0;
         run_access(bus_pkg::bus_write, b, {3'd1, off}, rand16());
         run_access(bus_pkg::bus_read, b, {3'd5, off}, 16'h0000);
      end

      // random access codes and lengths: aborts, odd traps and byte lanes
      for (int i = 0; i < n_abort; i++)
      begin
         if ((i % 75) == 0)
         begin
            for (int p = 0; p < 8; p++)
               load_page(3'(p), 12'($urandom()), 3'($urandom_range(0, 7)), 7'($urandom()));
         end
         k = ($urandom_range(0, 1) == 1) ? bus_pkg::bus_write : bus_pkg::bus_read;
         run_access(k, 1'($urandom_range(0, 1)), rand16(), rand16());
      end

      // nothing outside the modelled writes may have changed
      for (int i = 0; i < 131072; i++)
      begin
         assert (sram[i] === model_mem[i])
            else report_error($sformatf("SRAM word %06o is %04h, expected %04h",
                                        i, sram[i], model_mem[i]));
      end
      $display("Result: PASSED");
      $finish;
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge sysclk);
      $display("watchdog: the run hung and did not finish within %0d cycles", watchdog_cycles);
      $display("Result: FAILED");
      $fatal(1, "watchdog timeout");
   end

endmodule
